// File: source/engine_pkg.sv
`default_nettype none

package engine_pkg;

	// One Q8.8 element, also used for bias and result
	typedef logic signed [15:0] data_t;

	// Window accumulator, 64 full products plus bias
	typedef logic signed [39:0] acc_t;

	// Window count of one operation
	typedef logic [31:0] count_t;

	typedef enum logic [1:0] {
		op_conv,
		op_maxpool,
		op_avepool
	} op_kind_e;

	// Producer states
	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_release
	} fetch_state_e;

	// Power of two, 2 to 64
	localparam int DEFAULT_WINDOW_LEN = 4;

	// Power of two, at least 4
	localparam int DEFAULT_BUFFER_DEPTH = 8;

endpackage

`default_nettype wire

// File: source/operand_if.sv
`timescale 1ns/1ps
`default_nettype none

interface operand_if;
	import engine_pkg::*;

	logic strobe;
	data_t data;
	data_t weight;
	op_kind_e kind;
	logic win_last;
	logic op_last;
	// Back-pressure from the sink
	logic hold;

	modport source (
		output strobe, data, weight, kind, win_last, op_last,
		input hold
	);

	modport sink (
		input strobe, data, weight, kind, win_last, op_last,
		output hold
	);

endinterface

`default_nettype wire

// File: source/operand_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module operand_fetch #(
	parameter int WINDOW_LEN = engine_pkg::DEFAULT_WINDOW_LEN
) (
	input logic clk,
	input logic reset,
	input logic conv_ready,
	input logic maxpool_ready,
	input logic avepool_ready,
	input engine_pkg::count_t op_num,
	output logic data_fifo_rd_en,
	input engine_pkg::data_t data,
	output logic weight_fifo_rd_en,
	input engine_pkg::data_t weight,
	operand_if.source out
);
	import engine_pkg::*;

	localparam int ELEM_W = $clog2(WINDOW_LEN);
	localparam logic [ELEM_W-1:0] LAST_ELEM = ELEM_W'(WINDOW_LEN - 1);

	fetch_state_e state;
	op_kind_e kind_r;
	op_kind_e ready_kind;
	count_t op_num_r;
	count_t win_cnt;
	logic [ELEM_W-1:0] elem_cnt;
	logic any_ready;
	logic rd_en;
	logic win_last;
	logic op_last;

	// Tags of the read in flight
	logic push_pending;
	op_kind_e kind_d;
	logic win_last_d;
	logic op_last_d;

	assign any_ready = conv_ready | maxpool_ready | avepool_ready;

	// Conv wins over maxpool, maxpool over avepool
	always_comb begin
		if (conv_ready)
			ready_kind = op_conv;
		else if (maxpool_ready)
			ready_kind = op_maxpool;
		else
			ready_kind = op_avepool;
	end

	assign rd_en = (state == st_run) && !out.hold;
	assign win_last = (elem_cnt == LAST_ELEM);
	assign op_last = win_last && (win_cnt == op_num_r - count_t'(1));

	assign data_fifo_rd_en = rd_en;
	assign weight_fifo_rd_en = rd_en && (kind_r == op_conv);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			kind_r <= op_conv;
			op_num_r <= '0;
			win_cnt <= '0;
			elem_cnt <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (any_ready) begin
						kind_r <= ready_kind;
						op_num_r <= op_num;
						win_cnt <= '0;
						elem_cnt <= '0;
						// Zero windows is a no-op
						state <= (op_num == '0) ? st_release : st_run;
					end
				end
				st_run: begin
					if (rd_en) begin
						if (win_last) begin
							elem_cnt <= '0;
							win_cnt <= win_cnt + count_t'(1);
							if (op_last)
								state <= st_release;
						end else begin
							elem_cnt <= elem_cnt + 1'b1;
						end
					end
				end
				st_release: begin
					if (!any_ready)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			push_pending <= 1'b0;
		else
			push_pending <= rd_en;
	end

	always_ff @(posedge clk) begin
		kind_d <= kind_r;
		win_last_d <= win_last;
		op_last_d <= op_last;
	end

	// FIFO word arrives one cycle after its strobe
	assign out.strobe = push_pending;
	assign out.data = data;
	assign out.weight = (kind_d == op_conv) ? weight : '0;
	assign out.kind = kind_d;
	assign out.win_last = win_last_d;
	assign out.op_last = op_last_d;

	reads_within_op: assert property (@(posedge clk) disable iff (reset)
		data_fifo_rd_en |-> (win_cnt < op_num_r))
		else $error("read strobe beyond the last window");

endmodule

`default_nettype wire

// File: source/operand_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module operand_buffer #(
	parameter int BUFFER_DEPTH = engine_pkg::DEFAULT_BUFFER_DEPTH
) (
	input logic clk,
	input logic reset,
	operand_if.sink in,
	operand_if.source out
);
	import engine_pkg::*;

	localparam int PTR_W = $clog2(BUFFER_DEPTH);
	localparam logic [PTR_W:0] FULL_LEVEL = (PTR_W + 1)'(BUFFER_DEPTH);
	// Two slots kept for the read still in flight
	localparam logic [PTR_W:0] ALMOST_FULL_LEVEL = (PTR_W + 1)'(BUFFER_DEPTH - 2);

	data_t data_mem [BUFFER_DEPTH];
	data_t weight_mem [BUFFER_DEPTH];
	op_kind_e kind_mem [BUFFER_DEPTH];
	logic win_last_mem [BUFFER_DEPTH];
	logic op_last_mem [BUFFER_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;
	logic push;
	logic pop;
	logic empty;
	logic full;

	assign push = in.strobe;
	assign empty = (count == '0);
	assign full = (count == FULL_LEVEL);
	assign pop = !empty && !out.hold;

	assign in.hold = (count >= ALMOST_FULL_LEVEL);

	always_ff @(posedge clk) begin
		if (push) begin
			data_mem[wr_ptr] <= in.data;
			weight_mem[wr_ptr] <= in.weight;
			kind_mem[wr_ptr] <= in.kind;
			win_last_mem[wr_ptr] <= in.win_last;
			op_last_mem[wr_ptr] <= in.op_last;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign out.strobe = pop;
	assign out.data = data_mem[rd_ptr];
	assign out.weight = weight_mem[rd_ptr];
	assign out.kind = kind_mem[rd_ptr];
	assign out.win_last = win_last_mem[rd_ptr];
	assign out.op_last = op_last_mem[rd_ptr];

	no_push_full: assert property (@(posedge clk) disable iff (reset)
		full |-> !push)
		else $error("push into full buffer");

	empty_ptrs_equal: assert property (@(posedge clk) disable iff (reset)
		empty |-> (wr_ptr == rd_ptr))
		else $error("pointers differ on empty buffer");

endmodule

`default_nettype wire

// File: source/window_compute.sv
`timescale 1ns/1ps
`default_nettype none

module window_compute #(
	parameter int WINDOW_LEN = engine_pkg::DEFAULT_WINDOW_LEN
) (
	input logic clk,
	input logic reset,
	operand_if.sink in,
	input engine_pkg::data_t bias,
	output engine_pkg::data_t result,
	output logic result_valid,
	output logic conv_valid,
	output logic maxpool_valid,
	output logic avepool_valid
);
	import engine_pkg::*;

	localparam int AVG_SHIFT = $clog2(WINDOW_LEN);
	localparam acc_t SAT_MAX = 32767;
	localparam acc_t SAT_MIN = -32768;

	acc_t acc;
	acc_t contrib;
	acc_t combined;
	logic signed [31:0] product;
	data_t bias_r;
	data_t final_value;
	op_kind_e kind_r;
	logic op_last_r;
	logic first;
	logic finalize;

	// Q8.8 times Q8.8 gives Q16.16
	assign product = in.data * in.weight;

	always_comb begin
		case (in.kind)
			op_conv: contrib = acc_t'(product);
			default: contrib = acc_t'(in.data);
		endcase
	end

	always_comb begin
		case (in.kind)
			op_maxpool: combined = (contrib > acc) ? contrib : acc;
			default: combined = acc + contrib;
		endcase
	end

	always_comb begin
		acc_t conv_sum;
		acc_t conv_scaled;
		acc_t ave_scaled;
		conv_sum = acc + (acc_t'(bias_r) <<< 8);
		conv_scaled = conv_sum >>> 8;
		// Floor division by the window length
		ave_scaled = acc >>> AVG_SHIFT;
		case (kind_r)
			op_conv: begin
				if (conv_scaled > SAT_MAX)
					final_value = 16'sh7fff;
				else if (conv_scaled < SAT_MIN)
					final_value = 16'sh8000;
				else
					final_value = conv_scaled[15:0];
			end
			op_maxpool: final_value = acc[15:0];
			default: final_value = ave_scaled[15:0];
		endcase
	end

	// One bubble while the result is registered
	assign in.hold = finalize;

	always_ff @(posedge clk) begin
		if (in.strobe) begin
			acc <= first ? contrib : combined;
			kind_r <= in.kind;
			op_last_r <= in.op_last;
			if (in.win_last)
				bias_r <= bias;
		end
		if (finalize)
			result <= final_value;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			first <= 1'b1;
			finalize <= 1'b0;
			result_valid <= 1'b0;
			conv_valid <= 1'b0;
			maxpool_valid <= 1'b0;
			avepool_valid <= 1'b0;
		end else begin
			if (in.strobe)
				first <= in.win_last;
			finalize <= in.strobe && in.win_last;
			result_valid <= finalize;
			conv_valid <= finalize && op_last_r && (kind_r == op_conv);
			maxpool_valid <= finalize && op_last_r && (kind_r == op_maxpool);
			avepool_valid <= finalize && op_last_r && (kind_r == op_avepool);
		end
	end

	no_strobe_on_hold: assert property (@(posedge clk) disable iff (reset)
		in.hold |-> !in.strobe)
		else $error("element arrived during finalize");

endmodule

`default_nettype wire

// File: source/engine.sv
`timescale 1ns/1ps
`default_nettype none

module engine #(
	parameter int WINDOW_LEN = engine_pkg::DEFAULT_WINDOW_LEN,
	parameter int BUFFER_DEPTH = engine_pkg::DEFAULT_BUFFER_DEPTH
) (
	input logic clk,
	input logic reset,
	input logic conv_ready,
	input logic maxpool_ready,
	input logic avepool_ready,
	input engine_pkg::count_t op_num,
	output logic data_fifo_rd_en,
	input engine_pkg::data_t data,
	output logic weight_fifo_rd_en,
	input engine_pkg::data_t weight,
	input engine_pkg::data_t bias,
	output engine_pkg::data_t result,
	output logic result_valid,
	output logic conv_valid,
	output logic maxpool_valid,
	output logic avepool_valid
);

	operand_if fetch_to_buf ();
	operand_if buf_to_compute ();

	operand_fetch #(
		.WINDOW_LEN(WINDOW_LEN)
	) operand_fetch_inst (
		.clk(clk),
		.reset(reset),
		.conv_ready(conv_ready),
		.maxpool_ready(maxpool_ready),
		.avepool_ready(avepool_ready),
		.op_num(op_num),
		.data_fifo_rd_en(data_fifo_rd_en),
		.data(data),
		.weight_fifo_rd_en(weight_fifo_rd_en),
		.weight(weight),
		.out(fetch_to_buf.source)
	);

	operand_buffer #(
		.BUFFER_DEPTH(BUFFER_DEPTH)
	) operand_buffer_inst (
		.clk(clk),
		.reset(reset),
		.in(fetch_to_buf.sink),
		.out(buf_to_compute.source)
	);

	window_compute #(
		.WINDOW_LEN(WINDOW_LEN)
	) window_compute_inst (
		.clk(clk),
		.reset(reset),
		.in(buf_to_compute.sink),
		.bias(bias),
		.result(result),
		.result_valid(result_valid),
		.conv_valid(conv_valid),
		.maxpool_valid(maxpool_valid),
		.avepool_valid(avepool_valid)
	);

endmodule

`default_nettype wire

// File: sim/engine_tb.sv
`timescale 1ns/1ps
`default_nettype none

module engine_tb;
	import engine_pkg::*;

	localparam int WINDOW_LEN = DEFAULT_WINDOW_LEN;
	localparam int BUFFER_DEPTH = DEFAULT_BUFFER_DEPTH;
	localparam int AVG_SHIFT = $clog2(WINDOW_LEN);
	localparam int MEM_DEPTH = 256;
	// Windows over all tests
	localparam int TOTAL_WINDOWS = 9 + 6 + 6 + 4 + 3 + 5 + 4 + 2 + 3;
	localparam int TIMEOUT_CYCLES = 20 * TOTAL_WINDOWS * WINDOW_LEN + 1000;

	logic clk;
	logic reset;
	logic conv_ready;
	logic maxpool_ready;
	logic avepool_ready;
	count_t op_num;
	logic data_fifo_rd_en;
	data_t data;
	logic weight_fifo_rd_en;
	data_t weight;
	data_t bias;
	data_t result;
	logic result_valid;
	logic conv_valid;
	logic maxpool_valid;
	logic avepool_valid;

	// External FIFO contents, popped in order
	data_t data_mem [MEM_DEPTH];
	data_t weight_mem [MEM_DEPTH];
	int data_reads = 0;
	int weight_reads = 0;
	int data_base = 0;
	int weight_base = 0;

	data_t expected_q [$];
	logic [2:0] done_q [$];
	data_t compare_result;
	logic [2:0] compare_done;

	engine #(
		.WINDOW_LEN(WINDOW_LEN),
		.BUFFER_DEPTH(BUFFER_DEPTH)
	) engine_inst (
		.clk(clk),
		.reset(reset),
		.conv_ready(conv_ready),
		.maxpool_ready(maxpool_ready),
		.avepool_ready(avepool_ready),
		.op_num(op_num),
		.data_fifo_rd_en(data_fifo_rd_en),
		.data(data),
		.weight_fifo_rd_en(weight_fifo_rd_en),
		.weight(weight),
		.bias(bias),
		.result(result),
		.result_valid(result_valid),
		.conv_valid(conv_valid),
		.maxpool_valid(maxpool_valid),
		.avepool_valid(avepool_valid)
	);

	always #50 clk = ~clk;

	task automatic fail_run();
		$display("TB FAILED");
		$fatal(1, "simulation stopped");
	endtask

	// Word returned on the edge after its strobe
	always @(posedge clk) begin
		if (!reset && data_fifo_rd_en) begin
			data <= #1 data_mem[data_reads];
			data_reads <= data_reads + 1;
		end
	end

	always @(posedge clk) begin
		if (!reset && weight_fifo_rd_en) begin
			weight <= #1 weight_mem[weight_reads];
			weight_reads <= weight_reads + 1;
		end
	end

	function automatic data_t compute_window(input op_kind_e kind, input int index,
			input int w_index, input data_t win_bias);
		longint sum;
		longint best;
		longint scaled;
		sum = 0;
		best = data_mem[index];
		for (int i = 0; i < WINDOW_LEN; i++) begin
			if (kind == op_conv)
				sum += longint'(data_mem[index + i]) * longint'(weight_mem[w_index + i]);
			else
				sum += longint'(data_mem[index + i]);
			if (longint'(data_mem[index + i]) > best)
				best = data_mem[index + i];
		end
		case (kind)
			op_conv: begin
				scaled = (sum + longint'(win_bias) * 256) >>> 8;
				if (scaled > 32767)
					return 16'sh7fff;
				if (scaled < -32768)
					return 16'sh8000;
				return data_t'(scaled);
			end
			op_maxpool: return data_t'(best);
			// Arithmetic shift rounds toward minus infinity
			default: return data_t'(sum >>> AVG_SHIFT);
		endcase
	endfunction

	function automatic data_t small_value();
		int v;
		v = int'($urandom_range(1023)) - 512;
		return data_t'(v);
	endfunction

	function automatic logic done_of(input op_kind_e kind);
		case (kind)
			op_conv: return conv_valid;
			op_maxpool: return maxpool_valid;
			default: return avepool_valid;
		endcase
	endfunction

	task automatic fill_small(input int count);
		for (int i = 0; i < count; i++) begin
			data_mem[data_base + i] = small_value();
			weight_mem[weight_base + i] = small_value();
		end
	endtask

	task automatic fill_signed(input int count);
		for (int i = 0; i < count; i++)
			data_mem[data_base + i] = data_t'($urandom());
	endtask

	// Odd windows get negative weights and saturate low
	task automatic fill_large(input int count);
		data_t mag;
		for (int i = 0; i < count; i++) begin
			mag = data_t'($urandom_range(32'h7fff, 32'h6000));
			data_mem[data_base + i] = mag;
			weight_mem[weight_base + i] = ((i / WINDOW_LEN) % 2 == 1) ? -mag : mag;
		end
	endtask

	task automatic set_ready(input op_kind_e kind, input logic level);
		conv_ready = level && (kind == op_conv);
		maxpool_ready = level && (kind == op_maxpool);
		avepool_ready = level && (kind == op_avepool);
	endtask

	task automatic run_op(input op_kind_e kind, input int windows, input data_t op_bias);
		int index;
		for (int w = 0; w < windows; w++) begin
			index = w * WINDOW_LEN;
			expected_q.push_back(compute_window(kind, data_base + index,
				weight_base + index, op_bias));
			if (w == windows - 1)
				done_q.push_back({kind == op_conv, kind == op_maxpool, kind == op_avepool});
			else
				done_q.push_back(3'b000);
		end
		@(posedge clk);
		#1;
		bias = op_bias;
		op_num = count_t'(windows);
		set_ready(kind, 1'b1);
		@(posedge clk);
		while (done_of(kind) !== 1'b1)
			@(posedge clk);
		#1;
		set_ready(kind, 1'b0);
		data_base += windows * WINDOW_LEN;
		if (kind == op_conv)
			weight_base += windows * WINDOW_LEN;
		assert (data_reads == data_base)
		else begin
			$display("** Error data_fifo_rd_en count: expected %h, actual %h",
				data_base, data_reads);
			fail_run();
		end
		assert (weight_reads == weight_base)
		else begin
			$display("** Error weight_fifo_rd_en count: expected %h, actual %h",
				weight_base, weight_reads);
			fail_run();
		end
	endtask

	task automatic run_empty_op(input op_kind_e kind);
		@(posedge clk);
		#1;
		op_num = '0;
		set_ready(kind, 1'b1);
		repeat (20) @(posedge clk);
		#1;
		set_ready(kind, 1'b0);
		assert (data_reads == data_base && weight_reads == weight_base)
		else begin
			$display("Reads were issued for an operation of zero windows");
			fail_run();
		end
	endtask

	// Compare each result and its done pulses
	always @(posedge clk) begin
		if (!reset) begin
			if (result_valid) begin
				assert (expected_q.size() > 0)
				else begin
					$display("A result arrived when none was expected");
					fail_run();
				end
				compare_result = expected_q.pop_front();
				compare_done = done_q.pop_front();
				assert (result === compare_result)
				else begin
					$display("** Error result: expected %h, actual %h", compare_result, result);
					fail_run();
				end
				assert ({conv_valid, maxpool_valid, avepool_valid} === compare_done)
				else begin
					$display("** Error {conv_valid,maxpool_valid,avepool_valid}: expected %h, actual %h",
						compare_done, {conv_valid, maxpool_valid, avepool_valid});
					fail_run();
				end
			end else begin
				assert ({conv_valid, maxpool_valid, avepool_valid} === 3'b000)
				else begin
					$display("A done pulse arrived without a result");
					fail_run();
				end
			end
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		fail_run();
	end

	initial begin
		int data_start;
		int weight_start;
		data_t op_bias;
		void'($urandom(32'h350fa8d9));
		clk = 1'b0;
		reset = 1'b1;
		set_ready(op_conv, 1'b0);
		op_num = '0;
		data = '0;
		weight = '0;
		bias = '0;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;

		fill_small(9 * WINDOW_LEN);
		weight_start = weight_reads;
		run_op(op_conv, 9, small_value());
		assert (weight_reads - weight_start == 9 * WINDOW_LEN)
		else begin
			$display("** Error weight_fifo_rd_en count: expected %h, actual %h",
				9 * WINDOW_LEN, weight_reads - weight_start);
			fail_run();
		end

		// Pooling must leave the weight FIFO alone
		weight_start = weight_reads;
		fill_signed(6 * WINDOW_LEN);
		run_op(op_maxpool, 6, '0);
		fill_signed(6 * WINDOW_LEN);
		run_op(op_avepool, 6, '0);
		assert (weight_reads == weight_start)
		else begin
			$display("The weight FIFO was read during pooling");
			fail_run();
		end

		fill_large(4 * WINDOW_LEN);
		run_op(op_conv, 4, small_value());

		// Back to back, one bias for the whole sequence
		data_start = data_reads;
		fill_small(14 * WINDOW_LEN);
		op_bias = small_value();
		run_op(op_avepool, 3, op_bias);
		run_op(op_conv, 5, op_bias);
		run_op(op_maxpool, 4, op_bias);
		run_op(op_avepool, 2, op_bias);
		assert (data_reads - data_start == 14 * WINDOW_LEN)
		else begin
			$display("** Error data_fifo_rd_en count: expected %h, actual %h",
				14 * WINDOW_LEN, data_reads - data_start);
			fail_run();
		end

		run_empty_op(op_maxpool);
		fill_signed(3 * WINDOW_LEN);
		run_op(op_avepool, 3, '0);

		repeat (4) @(posedge clk);
		if (expected_q.size() == 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			$display("Results were still expected at the end of the run");
			fail_run();
		end
	end

endmodule

`default_nettype wire

// File: filelist.f
source/engine_pkg.sv
source/operand_if.sv
source/operand_fetch.sv
source/operand_buffer.sv
source/window_compute.sv
source/engine.sv
sim/engine_tb.sv

// File: Bender.yml
package:
  name: engine

sources:
  - source/engine_pkg.sv
  - source/operand_if.sv
  - source/operand_fetch.sv
  - source/operand_buffer.sv
  - source/window_compute.sv
  - source/engine.sv
  - target: simulation
    files:
      - sim/engine_tb.sv
